// File: srt_div_macros.svh
`ifndef SRT_DIV_MACROS_SVH
`define SRT_DIV_MACROS_SVH

// operand width, keep it even so the radix-4 digit pairs line up
`define DIV_DATA_W 16

// normalized entries waiting between normalizer and core
`define DIV_FIFO_DEPTH 4

// radix-4 steps, two quotient bits each plus one spare step
`define DIV_ITERS ((`DIV_DATA_W / 2) + 1)

// width of the normalization shift amount
`define DIV_SHIFT_W ($clog2(`DIV_DATA_W))

`endif

// File: srt_div_pkg.sv
package srt_div_pkg;

	`include "srt_div_macros.svh"

	// iteration core FSM
	typedef enum logic [2:0] {
		IDLE,  // wait for a queued entry
		LOAD,  // set up remainder and quotient regs
		ITER,  // one radix-4 step per cycle
		FIX,   // sign correction and denormalize
		DONE   // results out, done high
	} div_state_e;

	// signed quotient digit, -2..+2, -1 is 3'b111
	typedef logic signed [2:0] qdigit_t;

	// one normalized operation
	typedef struct packed {
		logic [2*`DIV_DATA_W-1:0] dvd_sh;   // dividend << shamt, needs the double width
		logic [`DIV_DATA_W-1:0]   dvs_sh;   // divisor << shamt, msb set
		logic [`DIV_SHIFT_W-1:0]  shamt;    // leading zeros of divisor
		logic [`DIV_DATA_W-1:0]   dvd_orig; // raw dividend for the zero case
		logic                     dvs_zero; // divide by zero
	} norm_op_t;

endpackage

// File: norm_op_if.sv
`timescale 1ns/1ps

interface norm_op_if import srt_div_pkg::*; ();

	logic     push;     // strobe, entry written this edge
	norm_op_t wr_entry; // entry from normalizer
	logic     full;     // queue level
	logic     pop;      // strobe, head retired this edge
	norm_op_t rd_entry; // queue head, valid while !empty
	logic     empty;    // queue level

	// normalizer side
	modport producer (
		output push,
		output wr_entry,
		input  full
	);

	// the queue itself
	modport queue (
		input  push,
		input  wr_entry,
		output full,
		input  pop,
		output rd_entry,
		output empty
	);

	// iteration core side
	modport consumer (
		output pop,
		input  rd_entry,
		input  empty
	);

endinterface

// File: srt_normalizer.sv
`timescale 1ns/1ps

`include "srt_div_macros.svh"

module srt_normalizer import srt_div_pkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   start,
	input  logic [`DIV_DATA_W-1:0] dividend,
	input  logic [`DIV_DATA_W-1:0] divisor,
	output logic                   ready,
	norm_op_if.producer            q
);

	localparam int W   = `DIV_DATA_W;
	localparam int SHW = `DIV_SHIFT_W;

	logic [SHW-1:0] lz;       // leading zeros of divisor
	logic           dvs_zero;
	logic           accept;   // start taken this cycle

	// a push in flight may take the last slot, so hold off until it lands
	assign ready  = ~q.full & ~q.push;
	assign accept = start & ready;

	assign dvs_zero = (divisor == '0);

	// priority scan where the highest set bit wins
	always_comb begin
		lz = '0;
		for (int i = 0; i < W; i++) begin
			if (divisor[i])
				lz = SHW'(W - 1 - i);
		end
	end

	// entry fields latched on an accepted start
	always_ff @(posedge clk) begin
		if (accept) begin
			q.wr_entry.dvd_sh   <= {{W{1'b0}}, dividend} << lz; // spare top bits absorb shift
			q.wr_entry.dvs_sh   <= divisor << lz;               // msb now set
			q.wr_entry.shamt    <= lz;                          // 0 for zero divisor
			q.wr_entry.dvd_orig <= dividend;
			q.wr_entry.dvs_zero <= dvs_zero;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			q.push <= 1'b0;
		end else begin
			q.push <= accept; // one push per accepted start
		end
	end

endmodule

// File: op_fifo.sv
`timescale 1ns/1ps

`include "srt_div_macros.svh"

module op_fifo import srt_div_pkg::*; (
	input logic      clk,
	input logic      rst,
	norm_op_if.queue q
);

	localparam int DEPTH = `DIV_FIFO_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	norm_op_t   mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count; // entries held

	assign q.full     = (count == CNT_W'(DEPTH));
	assign q.empty    = (count == '0);
	assign q.rd_entry = mem[rd_ptr]; // head shows next cycle after push

	// entry storage
	always_ff @(posedge clk) begin
		if (q.push)
			mem[wr_ptr] <= q.wr_entry;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (q.push) begin
				// back to slot zero after the last slot
				if (wr_ptr == PTR_W'(DEPTH - 1))
					wr_ptr <= '0;
				else
					wr_ptr <= wr_ptr + 1'b1;
			end
			if (q.pop) begin
				if (rd_ptr == PTR_W'(DEPTH - 1))
					rd_ptr <= '0;
				else
					rd_ptr <= rd_ptr + 1'b1;
			end
			// push and pop together cancel out
			case ({q.push, q.pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: qds.sv
`timescale 1ns/1ps

module qds import srt_div_pkg::*; (
	input  logic [4:0] r_idx,   // 4w estimate, units of 1/8, two's complement
	input  logic [3:0] d_idx,   // divisor 1.xxx, top bit always set
	output qdigit_t    quotient
);

	logic       neg_r;  // remainder sign
	logic [4:0] r_mag;  // magnitude of estimate
	logic [3:0] t_lo;   // smallest magnitude giving digit 1
	logic [3:0] t_hi;   // smallest magnitude giving digit 2
	logic [4:0] lo_lim;
	logic [4:0] hi_lim;
	logic       q0;
	logic       q2;
	logic [1:0] q_mag;

	assign neg_r = r_idx[4];
	// core saturates to +-15, so the negate never wraps
	assign r_mag = neg_r ? (~r_idx + 5'd1) : r_idx;

	// boundaries per divisor interval
	always_comb begin
		case (d_idx)
			4'b1000: begin
				t_lo = 4'd2;
				t_hi = 4'd6;
			end
			4'b1001: begin
				t_lo = 4'd2;
				t_hi = 4'd7;
			end
			4'b1010: begin
				t_lo = 4'd2;
				t_hi = 4'd8;
			end
			4'b1011: begin
				t_lo = 4'd2;
				t_hi = 4'd8;
			end
			4'b1100: begin
				t_lo = 4'd3;
				t_hi = 4'd9;
			end
			4'b1101: begin
				t_lo = 4'd3;
				t_hi = 4'd10;
			end
			4'b1110: begin
				t_lo = 4'd3;
				t_hi = 4'd10;
			end
			4'b1111: begin
				t_lo = 4'd3;
				t_hi = 4'd11;
			end
			default: begin // unnormalized divisor, never seen
				t_lo = 4'd15;
				t_hi = 4'd15;
			end
		endcase
	end

	// a negative estimate is floored, so its magnitude reads one high
	assign lo_lim = {1'b0, t_lo} + 5'(neg_r);
	assign hi_lim = {1'b0, t_hi} + 5'(neg_r);

	assign q0    = (r_mag < lo_lim);
	assign q2    = (r_mag >= hi_lim);
	assign q_mag = q0 ? 2'b00 : (q2 ? 2'b10 : 2'b01);

	// sign applied as two's complement, -1 comes out 3'b111
	assign quotient = qdigit_t'(neg_r ? (3'd0 - {1'b0, q_mag}) : {1'b0, q_mag});

endmodule

// File: srt_iter_core.sv
`timescale 1ns/1ps

`include "srt_div_macros.svh"

module srt_iter_core import srt_div_pkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	norm_op_if.consumer            q,
	output logic                   done,
	output logic [`DIV_DATA_W-1:0] quotient,
	output logic [`DIV_DATA_W-1:0] remainder,
	output logic                   div_zero
);

	localparam int W     = `DIV_DATA_W;
	localparam int RW    = 2 * W + 5;          // 3 int bits incl sign, 2W+2 frac bits
	localparam int QW    = 2 * `DIV_ITERS;     // on-the-fly quotient width
	localparam int CNT_W = $clog2(`DIV_ITERS + 1);

	div_state_e state;
	norm_op_t   ent_r;                  // popped entry
	logic signed [RW-1:0] rem_r;        // partial remainder
	logic signed [RW-1:0] rem_sh;       // 4 * rem
	logic signed [RW-1:0] rem_nxt;
	logic signed [RW-1:0] dvs_al;       // divisor aligned to remainder point
	logic [QW-1:0]    qp_r;             // quotient
	logic [QW-1:0]    qn_r;             // quotient minus one
	logic [QW-1:0]    qp_nxt;
	logic [QW-1:0]    qn_nxt;
	logic [CNT_W-1:0] cnt;
	logic signed [5:0] est;             // 4w in 1/8 units
	logic [4:0]        r_idx;
	qdigit_t           qd;
	logic signed [W+2:0] rem_int;       // final remainder, still normalized
	logic signed [W+2:0] rem_fix;
	logic [W-1:0]        q_fix;

	assign q.pop = (state == IDLE) & ~q.empty; // pop and capture together
	assign done  = (state == DONE);

	assign rem_sh = rem_r <<< 2;
	assign dvs_al = {3'b000, ent_r.dvs_sh, {(W + 2){1'b0}}};

	// estimate for the table, clamped to +-15
	assign est = rem_sh[RW-1 -: 6];
	always_comb begin
		if (est > 6'sd15)
			r_idx = 5'd15;
		else if (est < -6'sd15)
			r_idx = 5'b10001;
		else
			r_idx = est[4:0];
	end

	qds u_qds (
		.r_idx    (r_idx),
		.d_idx    (ent_r.dvs_sh[W-1 -: 4]),
		.quotient (qd)
	);

	// rem = 4*rem - qd*d
	always_comb begin
		case (qd)
			3'sd2:   rem_nxt = rem_sh - (dvs_al <<< 1);
			3'sd1:   rem_nxt = rem_sh - dvs_al;
			-3'sd1:  rem_nxt = rem_sh + dvs_al;
			-3'sd2:  rem_nxt = rem_sh + (dvs_al <<< 1);
			default: rem_nxt = rem_sh;
		endcase
	end

	// on-the-fly conversion, digit low bits equal qd mod 4
	always_comb begin
		if (qd > 0) begin
			qp_nxt = {qp_r[QW-3:0], qd[1:0]};
			qn_nxt = {qp_r[QW-3:0], qd[1:0] - 2'd1};
		end else if (qd < 0) begin
			qp_nxt = {qn_r[QW-3:0], qd[1:0]};
			qn_nxt = {qn_r[QW-3:0], qd[1:0] - 2'd1};
		end else begin
			qp_nxt = {qp_r[QW-3:0], 2'b00};
			qn_nxt = {qn_r[QW-3:0], 2'b11};
		end
	end

	// low W+2 bits are zero after the last step
	assign rem_int = rem_r[RW-1 -: W + 3];
	always_comb begin
		if (rem_int < 0) begin
			rem_fix = rem_int + $signed({3'b000, ent_r.dvs_sh}); // one divisor back
			q_fix   = qn_r[W-1:0];
		end else begin
			rem_fix = rem_int;
			q_fix   = qp_r[W-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			cnt   <= '0;
		end else begin
			case (state)
				IDLE: if (!q.empty) state <= LOAD;
				LOAD: begin
					cnt   <= '0;
					state <= ent_r.dvs_zero ? FIX : ITER; // nothing to iterate
				end
				ITER: begin
					cnt <= cnt + 1'b1;
					if (cnt == CNT_W'(`DIV_ITERS - 1))
						state <= FIX;
				end
				FIX:     state <= DONE;
				default: state <= IDLE; // DONE
			endcase
		end
	end

	// datapath and result regs, held until the next FIX
	always_ff @(posedge clk) begin
		if (q.pop)
			ent_r <= q.rd_entry;
		case (state)
			LOAD: begin
				rem_r <= $signed({5'b00000, ent_r.dvd_sh});
				qp_r  <= '0;
				qn_r  <= '1; // zero minus one
			end
			ITER: begin
				rem_r <= rem_nxt;
				qp_r  <= qp_nxt;
				qn_r  <= qn_nxt;
			end
			FIX: begin
				div_zero <= ent_r.dvs_zero;
				if (ent_r.dvs_zero) begin
					quotient  <= '1;
					remainder <= ent_r.dvd_orig;
				end else begin
					quotient  <= q_fix;
					remainder <= rem_fix[W-1:0] >> ent_r.shamt; // undo normalization
				end
			end
			default: ;
		endcase
	end

endmodule

// File: srt_div.sv
`timescale 1ns/1ps

`include "srt_div_macros.svh"

module srt_div import srt_div_pkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   start,
	input  logic [`DIV_DATA_W-1:0] dividend,
	input  logic [`DIV_DATA_W-1:0] divisor,
	output logic                   ready,
	output logic                   done,
	output logic [`DIV_DATA_W-1:0] quotient,
	output logic [`DIV_DATA_W-1:0] remainder,
	output logic                   div_zero
);

	norm_op_if op_q (); // normalizer -> queue -> core

	srt_normalizer u_norm (
		.clk      (clk),
		.rst      (rst),
		.start    (start),
		.dividend (dividend),
		.divisor  (divisor),
		.ready    (ready),
		.q        (op_q.producer)
	);

	op_fifo u_fifo (
		.clk (clk),
		.rst (rst),
		.q   (op_q.queue)
	);

	srt_iter_core u_core (
		.clk       (clk),
		.rst       (rst),
		.q         (op_q.consumer),
		.done      (done),
		.quotient  (quotient),
		.remainder (remainder),
		.div_zero  (div_zero)
	);

endmodule

// File: tb_srt_div.sv
`timescale 1ns/1ps

`include "srt_div_macros.svh"

module tb_srt_div import srt_div_pkg::*; ();

	localparam int W       = `DIV_DATA_W;
	localparam int LAT     = `DIV_ITERS + 4;      // start edge to done on an idle design
	localparam int N_RAND  = 40;
	localparam int N_DIR   = 10;
	localparam int N_ZERO  = 2;
	localparam int N_BP    = 24;                  // back-to-back start cycles
	localparam int N_OPS   = 1 + N_RAND + N_DIR + N_ZERO + N_BP;
	localparam int T_LIMIT = N_OPS * LAT + 500;   // reset, gaps and drain

	logic         clk;
	logic         rst;
	logic         start;
	logic [W-1:0] dividend;
	logic [W-1:0] divisor;
	logic         ready;
	logic         done;
	logic [W-1:0] quotient;
	logic [W-1:0] remainder;
	logic         div_zero;

	logic [31:0]  lfsr;
	int           cyc;
	int           errors;
	int           checks;
	int           err_mark;
	int           test_no;
	int           done_cyc;
	logic [W-1:0] exp_q[$];   // model results in issue order
	logic [W-1:0] exp_r[$];
	logic         exp_z[$];
	logic [W-1:0] m_q;
	logic [W-1:0] m_r;
	logic         m_z;

	srt_div uut (
		.clk       (clk),
		.rst       (rst),
		.start     (start),
		.dividend  (dividend),
		.divisor   (divisor),
		.ready     (ready),
		.done      (done),
		.quotient  (quotient),
		.remainder (remainder),
		.div_zero  (div_zero)
	);

	always #4 clk = ~clk; // 8 ns period

	// taps 32,22,2,1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr); // one step per bit
			v    = {v[30:0], lfsr[0]};
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s: got %h expected %h", name, got, exp);
		end
	endtask

	// reference results straight from integer division
	task automatic model_push(input logic [W-1:0] a, input logic [W-1:0] b);
		if (b == '0) begin
			exp_q.push_back('1);
			exp_r.push_back(a);
			exp_z.push_back(1'b1);
		end else begin
			exp_q.push_back(a / b);
			exp_r.push_back(a % b);
			exp_z.push_back(1'b0);
		end
	endtask

	// drives one start cycle once ready and returns its sampling edge
	task automatic issue_op(input logic [W-1:0] a, input logic [W-1:0] b, output int edge_no);
		@(negedge clk);
		while (!ready)
			@(negedge clk);
		start    = 1'b1;
		dividend = a;
		divisor  = b;
		edge_no  = cyc + 1;
		model_push(a, b);
		@(negedge clk);
		start = 1'b0;
	endtask

	task automatic wait_drain();
		while (exp_q.size() != 0)
			@(negedge clk);
	endtask

	task automatic run_op(input logic [W-1:0] a, input logic [W-1:0] b);
		int e;
		issue_op(a, b, e);
		wait_drain();
	endtask

	task automatic finish_test(input string name);
		test_no++;
		$display("test %0d %s: %s (%0d errors)", test_no, name,
			(errors == err_mark) ? "ok" : "failed", errors - err_mark);
		err_mark = errors;
	endtask

	// result monitor sampling at the falling edge
	always @(negedge clk) begin
		if (!rst && done === 1'b1) begin
			done_cyc = cyc;
			if (exp_q.size() == 0) begin
				errors++;
				$display("done was raised with no operation outstanding");
			end else begin
				m_q = exp_q.pop_front();
				m_r = exp_r.pop_front();
				m_z = exp_z.pop_front();
				check_value("quotient", quotient, m_q);
				check_value("remainder", remainder, m_r);
				check_value("div_zero", div_zero, m_z);
			end
		end
	end

	// run limit
	always @(posedge clk) begin
		cyc++;
		if (cyc >= T_LIMIT) begin
			$display("timeout after %0d cycles, %0d results still outstanding",
				cyc, exp_q.size());
			$display("Finished with errors");
			$finish;
		end
	end

	initial begin
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] sh;
		int          st_edge;
		int          taken;
		int          dropped;
		int          low_run;
		int          max_low;
		clk      = 1'b0;
		rst      = 1'b1;
		start    = 1'b0;
		dividend = '0;
		divisor  = '0;
		lfsr     = 32'h9f083892;
		cyc      = 0;
		errors   = 0;
		checks   = 0;
		err_mark = 0;
		test_no  = 0;
		done_cyc = 0;
		repeat (10) @(negedge clk);
		rst = 1'b0;

		// reset state and one op on an idle design
		@(negedge clk);
		check_value("ready", ready, 1'b1);
		check_value("done", done, 1'b0);
		issue_op(16'hd00d, 16'h0123, st_edge);
		wait_drain();
		check_value("latency", done_cyc - st_edge, LAT);
		finish_test("reset and latency");

		for (int i = 0; i < N_RAND; i++) begin
			rand_bits(W, a);
			rand_bits(W, b);
			rand_bits(4, sh);
			run_op(a[W-1:0], b[W-1:0] >> sh); // spread the leading zero count
		end
		finish_test("random operands");

		run_op(16'h1234, 16'h0001);   // divisor 1
		run_op(16'hbeef, 16'hffff);   // divisor all ones
		run_op(16'h0005, 16'h0009);   // dividend below divisor
		run_op(16'h7777, 16'h7777);   // equal
		run_op(16'h0000, 16'h1357);   // zero dividend
		run_op(16'hffff, 16'hffff);   // both max
		run_op(16'hffff, 16'h8000);   // top bit only, no shift
		run_op(16'hffff, 16'h0001);   // bottom bit only, full shift
		run_op(16'h8001, 16'h8000);
		run_op(16'h4321, 16'h0002);
		finish_test("directed edges");

		run_op(16'habcd, 16'h0000);
		run_op(16'h0000, 16'h0000);
		finish_test("zero divisor");

		// start held every cycle
		taken   = 0;
		dropped = 0;
		low_run = 0;
		max_low = 0;
		for (int i = 0; i < N_BP; i++) begin
			@(negedge clk);
			rand_bits(W, a);
			rand_bits(W, b);
			start    = 1'b1;
			dividend = a[W-1:0];
			divisor  = b[W-1:0];
			if (ready) begin
				model_push(a[W-1:0], b[W-1:0]);
				taken++;
				low_run = 0;
			end else begin
				dropped++;
				low_run++;
				if (low_run > max_low)
					max_low = low_run;
			end
		end
		@(negedge clk);
		start = 1'b0;
		if (max_low < 2) begin // one low cycle is just the pending push
			errors++;
			$display("ready never dropped for a full queue under back-pressure");
		end
		wait_drain();
		@(negedge clk);
		check_value("ready", ready, 1'b1);
		finish_test($sformatf("back-pressure (%0d starts taken, %0d dropped)",
			taken, dropped));

		// a dropped start that slipped in would show up as a stray done here
		repeat (LAT) @(negedge clk);
		$display("%0d tests, %0d checks, %0d errors", test_no, checks, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// File: srt_div.f
+incdir+.
srt_div_pkg.sv
norm_op_if.sv
srt_normalizer.sv
op_fifo.sv
qds.sv
srt_iter_core.sv
srt_div.sv
tb_srt_div.sv
